// File: verilog/htif_axi_pkg.sv
package htif_axi_pkg;

  // one data word, same width on the bus and toward the target
  typedef logic [31:0] htif_word_t;

  // processor-side transaction id
  typedef logic [11:0] htif_axi_id_t;

  // aw and ar channels share one layout
  typedef struct packed {
    htif_axi_id_t id;
    logic [31:0]  addr;
  } htif_addr_req_t;

  // write data beat
  // strobe rides along but the bridge always takes the full word
  typedef struct packed {
    htif_word_t data;
    logic [3:0] strb;
  } htif_wr_beat_t;

  // read data beat, single beat so last is high on every one
  typedef struct packed {
    htif_axi_id_t id;
    htif_word_t   data;
    logic         last;
  } htif_rd_beat_t;

  // register index field inside the byte address
  // word aligned, 32 registers per direction
  localparam int HTIF_REG_LSB = 2;
  localparam int HTIF_REG_MSB = 6;

endpackage

// File: verilog/htif_reg_pkg.sv
package htif_reg_pkg;

  // write side register map
  typedef enum logic [4:0] {
    WR_FIFO  = 5'd0,
    WR_RESET = 5'd31
  } htif_wr_reg_e;

  // read side register map
  typedef enum logic [4:0] {
    RD_COUNT = 5'd0,
    RD_FIFO  = 5'd1
  } htif_rd_reg_e;

  // write channel FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WRITE,
    WR_ACK
  } htif_wr_state_e;

  // read channel FSM
  typedef enum logic {
    RD_IDLE,
    RD_READ
  } htif_rd_state_e;

endpackage

// File: verilog/host_fifo.sv
`timescale 1ns/1ps

module host_fifo
  import htif_axi_pkg::*;
#(
  parameter int FIFO_DEPTH = 32
)
(
  input  logic                          host_clk,
  input  logic                          reset,
  input  logic                          push,
  input  htif_word_t                    push_data,
  output logic                          push_ready,
  input  logic                          pop,
  output htif_word_t                    pop_data,
  output logic                          pop_valid,
  output logic [$clog2(FIFO_DEPTH):0]   count
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(FIFO_DEPTH);

  htif_word_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             empty_q;
  logic             full_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  // requests outside the ready/valid window are dropped
  assign do_push = push && !full_q;
  assign do_pop  = pop && !empty_q;

  // storage only, no reset
  always_ff @(posedge host_clk)
  begin
    if (do_push)
      mem[wr_ptr_q] <= push_data;
  end

  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      empty_q  <= 1'b1;
      full_q   <= 1'b0;
      count_q  <= '0;
    end
    else
    begin
      // pointers wrap naturally, depth is a power of two
      if (do_push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // simultaneous push and pop leaves count and flags alone
      if (do_push && !do_pop)
      begin
        count_q <= count_q + 1'b1;
        empty_q <= 1'b0;
        full_q  <= (count_q == FULL_COUNT - 1'b1);
      end
      else if (do_pop && !do_push)
      begin
        count_q <= count_q - 1'b1;
        full_q  <= 1'b0;
        empty_q <= (count_q == 1);
      end
    end
  end

  assign push_ready = !full_q;
  assign pop_valid  = !empty_q;
  // head of queue shown whether popped or not
  assign pop_data   = mem[rd_ptr_q];
  assign count      = count_q;

  // occupancy bounded and flags consistent with it
  assert property (@(posedge host_clk) disable iff (reset)
    (count_q <= FULL_COUNT) && !(empty_q && full_q));

endmodule

// File: verilog/htif_write_port.sv
`timescale 1ns/1ps

module htif_write_port
  import htif_axi_pkg::*;
  import htif_reg_pkg::*;
(
  input  logic           host_clk,
  input  logic           reset,
  input  htif_addr_req_t aw_req,
  input  logic           aw_valid,
  input  htif_wr_beat_t  w_beat,
  input  logic           w_valid,
  output logic           aw_ready,
  output logic           w_ready,
  output htif_axi_id_t   b_id,
  output logic           b_valid,
  input  logic           b_ready,
  input  logic           fifo_push_ready,
  output logic           fifo_push,
  output htif_word_t     fifo_push_data,
  output logic           target_reset
);

  htif_wr_state_e state_q;
  htif_wr_reg_e   wr_index_q;
  htif_axi_id_t   aw_id_q;
  htif_word_t     wr_data_q;
  logic           write_done;

  // fifo writes wait for room, everything else finishes at once
  always_comb
  begin
    case (wr_index_q)
      WR_FIFO: write_done = fifo_push_ready;
      default: write_done = 1'b1;
    endcase
  end

  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      state_q <= WR_IDLE;
    end
    else
    begin
      case (state_q)
        WR_IDLE:
          if (aw_valid && w_valid)
            state_q <= WR_WRITE;
        WR_WRITE:
          if (write_done)
            state_q <= WR_ACK;
        WR_ACK:
          if (b_ready)
            state_q <= WR_IDLE;
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  // address, id and data captured together
  always_ff @(posedge host_clk)
  begin
    if (state_q == WR_IDLE && aw_valid && w_valid)
    begin
      wr_index_q <= htif_wr_reg_e'(aw_req.addr[HTIF_REG_MSB:HTIF_REG_LSB]);
      aw_id_q    <= aw_req.id;
      wr_data_q  <= w_beat.data;
    end
  end

  // both channels accepted in the completing cycle
  assign aw_ready       = (state_q == WR_WRITE) && write_done;
  assign w_ready        = aw_ready;
  assign fifo_push      = aw_ready && (wr_index_q == WR_FIFO);
  assign fifo_push_data = wr_data_q;
  // one cycle pulse, WR_WRITE never lasts more than one cycle for this index
  assign target_reset   = aw_ready && (wr_index_q == WR_RESET);
  assign b_valid        = (state_q == WR_ACK);
  assign b_id           = aw_id_q;

  // reset pulse only right after a request to index 31 was taken
  assert property (@(posedge host_clk) disable iff (reset)
    target_reset |-> $past(state_q == WR_IDLE && aw_valid && w_valid &&
                           aw_req.addr[HTIF_REG_MSB:HTIF_REG_LSB] == WR_RESET));

  // response held until taken
  assert property (@(posedge host_clk) disable iff (reset)
    b_valid && !b_ready |=> b_valid && $stable(b_id));

endmodule

// File: verilog/htif_read_port.sv
`timescale 1ns/1ps

module htif_read_port
  import htif_axi_pkg::*;
  import htif_reg_pkg::*;
#(
  parameter int FIFO_DEPTH = 32
)
(
  input  logic                          host_clk,
  input  logic                          reset,
  input  htif_addr_req_t                ar_req,
  input  logic                          ar_valid,
  output logic                          ar_ready,
  output htif_rd_beat_t                 r_beat,
  output logic                          r_valid,
  input  logic                          r_ready,
  output logic                          fifo_pop,
  input  htif_word_t                    fifo_pop_data,
  input  logic [$clog2(FIFO_DEPTH):0]   fifo_count
);

  htif_rd_state_e state_q;
  htif_rd_reg_e   rd_index_q;
  htif_axi_id_t   ar_id_q;

  always_ff @(posedge host_clk)
  begin
    if (reset)
      state_q <= RD_IDLE;
    else if (state_q == RD_IDLE && ar_valid)
      state_q <= RD_READ;
    else if (state_q == RD_READ && r_ready)
      state_q <= RD_IDLE;
  end

  // request fields taken in the accepting cycle
  always_ff @(posedge host_clk)
  begin
    if (state_q == RD_IDLE && ar_valid)
    begin
      rd_index_q <= htif_rd_reg_e'(ar_req.addr[HTIF_REG_MSB:HTIF_REG_LSB]);
      ar_id_q    <= ar_req.id;
    end
  end

  assign ar_ready = (state_q == RD_IDLE);
  assign r_valid  = (state_q == RD_READ);

  // count zero-extended, any other index shows the head
  assign r_beat.id   = ar_id_q;
  assign r_beat.data = (rd_index_q == RD_COUNT) ? htif_word_t'(fifo_count) : fifo_pop_data;
  assign r_beat.last = r_valid;

  // pop only once the data beat is accepted
  assign fifo_pop = r_valid && r_ready && (rd_index_q == RD_FIFO);

  // accepted request answered next cycle under its own id
  assert property (@(posedge host_clk) disable iff (reset)
    ar_valid && ar_ready |=> r_valid && (r_beat.id == $past(ar_req.id)));

endmodule

// File: verilog/htif_axi_bridge.sv
`timescale 1ns/1ps

module htif_axi_bridge
  import htif_axi_pkg::*;
#(
  parameter int FIFO_DEPTH = 32
)
(
  input  logic           host_clk,
  input  logic           reset,
  // processor side
  input  htif_addr_req_t aw_req,
  input  logic           aw_valid,
  output logic           aw_ready,
  input  htif_wr_beat_t  w_beat,
  input  logic           w_valid,
  output logic           w_ready,
  output htif_axi_id_t   b_id,
  output logic           b_valid,
  input  logic           b_ready,
  input  htif_addr_req_t ar_req,
  input  logic           ar_valid,
  output logic           ar_ready,
  output htif_rd_beat_t  r_beat,
  output logic           r_valid,
  input  logic           r_ready,
  // target side
  output htif_word_t     host_in_bits,
  output logic           host_in_valid,
  input  logic           host_in_ready,
  input  htif_word_t     host_out_bits,
  input  logic           host_out_valid,
  output logic           host_out_ready,
  output logic           target_reset
);

  localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

  logic             in_push;
  logic             in_push_ready;
  htif_word_t       in_push_data;
  logic             out_pop;
  htif_word_t       out_pop_data;
  logic [CNT_W-1:0] out_count;

  htif_write_port u_write_port (
    .host_clk        (host_clk),
    .reset           (reset),
    .aw_req          (aw_req),
    .aw_valid        (aw_valid),
    .w_beat          (w_beat),
    .w_valid         (w_valid),
    .aw_ready        (aw_ready),
    .w_ready         (w_ready),
    .b_id            (b_id),
    .b_valid         (b_valid),
    .b_ready         (b_ready),
    .fifo_push_ready (in_push_ready),
    .fifo_push       (in_push),
    .fifo_push_data  (in_push_data),
    .target_reset    (target_reset)
  );

  // processor to target, target drains with host_in_ready
  host_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_host_in_fifo (
    .host_clk   (host_clk),
    .reset      (reset),
    .push       (in_push),
    .push_data  (in_push_data),
    .push_ready (in_push_ready),
    .pop        (host_in_ready),
    .pop_data   (host_in_bits),
    .pop_valid  (host_in_valid),
    .count      ()
  );

  // target to processor, full queue drops host_out_ready
  host_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_host_out_fifo (
    .host_clk   (host_clk),
    .reset      (reset),
    .push       (host_out_valid),
    .push_data  (host_out_bits),
    .push_ready (host_out_ready),
    .pop        (out_pop),
    .pop_data   (out_pop_data),
    .pop_valid  (),
    .count      (out_count)
  );

  htif_read_port #(.FIFO_DEPTH(FIFO_DEPTH)) u_read_port (
    .host_clk      (host_clk),
    .reset         (reset),
    .ar_req        (ar_req),
    .ar_valid      (ar_valid),
    .ar_ready      (ar_ready),
    .r_beat        (r_beat),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .fifo_pop      (out_pop),
    .fifo_pop_data (out_pop_data),
    .fifo_count    (out_count)
  );

endmodule

// File: verification/htif_axi_bridge_tb.sv
`timescale 1ns/1ps

module htif_axi_bridge_tb
  import htif_axi_pkg::*;
();

  localparam int FIFO_DEPTH = 32;
  // all six tests together take under 500 cycles, the back-pressure test about 210
  localparam int TIMEOUT_CYCLES = 2000;

  logic           host_clk;
  logic           reset;
  htif_addr_req_t aw_req;
  logic           aw_valid;
  logic           aw_ready;
  htif_wr_beat_t  w_beat;
  logic           w_valid;
  logic           w_ready;
  htif_axi_id_t   b_id;
  logic           b_valid;
  logic           b_ready;
  htif_addr_req_t ar_req;
  logic           ar_valid;
  logic           ar_ready;
  htif_rd_beat_t  r_beat;
  logic           r_valid;
  logic           r_ready;
  htif_word_t     host_in_bits;
  logic           host_in_valid;
  logic           host_in_ready;
  htif_word_t     host_out_bits;
  logic           host_out_valid;
  logic           host_out_ready;
  logic           target_reset;

  integer     seed;
  int         error_count;
  int         check_count;
  int         cycle_count;
  int         reset_pulses;
  string      test_name;
  // words written over the bus, and words seen leaving toward the target
  htif_word_t exp_q[$];
  htif_word_t rx_q[$];

  htif_axi_bridge #(.FIFO_DEPTH(FIFO_DEPTH)) dut (.*);

  initial
  begin
    host_clk = 1'b0;
    forever #2 host_clk = ~host_clk;
  end

  always @(posedge host_clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("Finished with errors");
      $finish;
    end
  end

  // negedge view of the target side
  // a word moves on the next rising edge
  always @(negedge host_clk)
  begin
    if (!reset && host_in_valid && host_in_ready)
      rx_q.push_back(host_in_bits);
    if (!reset && target_reset)
      reset_pulses = reset_pulses + 1;
  end

  task automatic check_word(input string what, input htif_word_t expected,
                            input htif_word_t actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("Mismatch in %s, %s: expected 0x%08h, actual 0x%08h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic check_id(input string what, input htif_axi_id_t expected,
                          input htif_axi_id_t actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("Mismatch in %s, %s: expected 0x%03h, actual 0x%03h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("Mismatch in %s, %s: expected %b, actual %b",
               test_name, what, expected, actual);
    end
  endtask

  // aw and w offered together, dropped after the accepting edge
  task automatic axi_write(input logic [31:0] addr, input htif_axi_id_t id,
                           input htif_word_t data, output htif_axi_id_t bid,
                           output logic reset_seen);
    @(posedge host_clk);
    aw_req.id   <= id;
    aw_req.addr <= addr;
    aw_valid    <= 1'b1;
    w_beat.data <= data;
    w_beat.strb <= 4'hf;
    w_valid     <= 1'b1;
    @(negedge host_clk);
    while (!aw_ready)
      @(negedge host_clk);
    check_bit("w_ready with aw_ready", 1'b1, w_ready);
    reset_seen = target_reset;
    @(posedge host_clk);
    aw_valid <= 1'b0;
    w_valid  <= 1'b0;
    b_ready  <= 1'b1;
    @(negedge host_clk);
    // response due one cycle after the accepting cycle
    check_bit("b_valid one cycle after ready", 1'b1, b_valid);
    while (!b_valid)
      @(negedge host_clk);
    bid = b_id;
    @(posedge host_clk);
    b_ready <= 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, input htif_axi_id_t id,
                          output htif_rd_beat_t beat);
    @(posedge host_clk);
    ar_req.id   <= id;
    ar_req.addr <= addr;
    ar_valid    <= 1'b1;
    @(negedge host_clk);
    while (!ar_ready)
      @(negedge host_clk);
    @(posedge host_clk);
    ar_valid <= 1'b0;
    r_ready  <= 1'b1;
    @(negedge host_clk);
    while (!r_valid)
      @(negedge host_clk);
    beat = r_beat;
    @(posedge host_clk);
    r_ready <= 1'b0;
  endtask

  // target side push, held until host_out_ready takes it
  task automatic target_push(input htif_word_t word);
    @(posedge host_clk);
    host_out_bits  <= word;
    host_out_valid <= 1'b1;
    @(negedge host_clk);
    while (!host_out_ready)
      @(negedge host_clk);
    @(posedge host_clk);
    host_out_valid <= 1'b0;
  endtask

  // single read with random id, data, id and last all checked
  task automatic read_and_compare(input logic [31:0] addr, input htif_word_t expected,
                                  input string what);
    htif_axi_id_t  id;
    htif_rd_beat_t beat;
    id = htif_axi_id_t'($random(seed));
    axi_read(addr, id, beat);
    check_word(what, expected, beat.data);
    check_id({what, " rid"}, id, beat.id);
    check_bit({what, " last"}, 1'b1, beat.last);
  endtask

  // fifo port write, expected word queued for the drain check
  task automatic write_host_word(input htif_word_t data);
    htif_axi_id_t id;
    htif_axi_id_t bid;
    logic         reset_seen;
    id = htif_axi_id_t'($random(seed));
    exp_q.push_back(data);
    axi_write(32'h0, id, data, bid, reset_seen);
    check_id("b_id", id, bid);
    check_bit("no target_reset on fifo write", 1'b0, reset_seen);
  endtask

  task automatic compare_drained(input int n);
    while (rx_q.size() < n)
      @(negedge host_clk);
    check_word("drained word count", n, rx_q.size());
    for (int i = 0; i < n; i++)
      check_word($sformatf("host_in word %0d", i), exp_q[i], rx_q[i]);
    exp_q.delete();
    rx_q.delete();
  endtask

  task automatic after_reset_outputs();
    test_name = "after_reset_outputs";
    @(negedge host_clk);
    check_bit("ar_ready", 1'b1, ar_ready);
    check_bit("host_out_ready", 1'b1, host_out_ready);
    check_bit("aw_ready", 1'b0, aw_ready);
    check_bit("w_ready", 1'b0, w_ready);
    check_bit("b_valid", 1'b0, b_valid);
    check_bit("r_valid", 1'b0, r_valid);
    check_bit("host_in_valid", 1'b0, host_in_valid);
    check_bit("target_reset", 1'b0, target_reset);
  endtask

  task automatic host_in_write_order();
    test_name = "host_in_write_order";
    @(posedge host_clk);
    host_in_ready <= 1'b1;
    repeat (8)
      write_host_word($random(seed));
    compare_drained(8);
  endtask

  task automatic host_out_read_order();
    htif_word_t words[5];
    test_name = "host_out_read_order";
    for (int i = 0; i < 5; i++)
    begin
      words[i] = $random(seed);
      target_push(words[i]);
    end
    read_and_compare(32'h0, 32'd5, "count after five pushes");
    for (int i = 0; i < 5; i++)
      read_and_compare(32'h4, words[i], $sformatf("host_out word %0d", i));
    read_and_compare(32'h0, 32'd0, "count after draining");
  endtask

  task automatic target_reset_pulse();
    htif_axi_id_t id;
    htif_axi_id_t bid;
    logic         reset_seen;
    int           pulses_before;
    test_name = "target_reset_pulse";
    pulses_before = reset_pulses;
    id = htif_axi_id_t'($random(seed));
    // index 31 of the write map
    axi_write(32'h7c, id, $random(seed), bid, reset_seen);
    check_bit("target_reset in accepting cycle", 1'b1, reset_seen);
    check_word("target_reset high cycles", 32'd1, reset_pulses - pulses_before);
    check_id("b_id", id, bid);
    @(negedge host_clk);
    check_bit("host_in_valid", 1'b0, host_in_valid);
    check_word("words sent to target", 32'd0, rx_q.size());
  endtask

  task automatic host_in_backpressure();
    htif_axi_id_t id;
    htif_axi_id_t bid;
    logic         reset_seen;
    htif_word_t   last_word;
    test_name = "host_in_backpressure";
    @(posedge host_clk);
    host_in_ready <= 1'b0;
    repeat (FIFO_DEPTH)
      write_host_word($random(seed));
    // stalled queue offers its oldest word to the target
    @(negedge host_clk);
    check_bit("host_in_valid while stalled", 1'b1, host_in_valid);
    check_word("host_in head while stalled", exp_q[0], host_in_bits);
    id = htif_axi_id_t'($random(seed));
    last_word = $random(seed);
    exp_q.push_back(last_word);
    // one more write stalls in WR_WRITE until the target drains
    fork
      axi_write(32'h0, id, last_word, bid, reset_seen);
      begin
        repeat (8)
        begin
          @(negedge host_clk);
          check_bit("b_valid while host_in full", 1'b0, b_valid);
          check_bit("aw_ready while host_in full", 1'b0, aw_ready);
        end
        @(posedge host_clk);
        host_in_ready <= 1'b1;
      end
    join
    check_id("b_id of stalled write", id, bid);
    compare_drained(FIFO_DEPTH + 1);
  endtask

  task automatic host_out_fill();
    int pushed;
    test_name = "host_out_fill";
    pushed = 0;
    @(negedge host_clk);
    // bounded in case host_out_ready never drops
    while (host_out_ready && pushed < FIFO_DEPTH + 4)
    begin
      target_push($random(seed));
      pushed++;
      @(negedge host_clk);
    end
    check_bit("host_out_ready when full", 1'b0, host_out_ready);
    check_word("words accepted", FIFO_DEPTH, pushed);
    read_and_compare(32'h0, FIFO_DEPTH, "count when full");
  endtask

  initial
  begin
    seed         = 30040;
    error_count  = 0;
    check_count  = 0;
    cycle_count  = 0;
    reset_pulses = 0;
    test_name    = "init";
    reset          <= 1'b1;
    aw_req         <= '0;
    aw_valid       <= 1'b0;
    w_beat         <= '0;
    w_valid        <= 1'b0;
    b_ready        <= 1'b0;
    ar_req         <= '0;
    ar_valid       <= 1'b0;
    r_ready        <= 1'b0;
    host_in_ready  <= 1'b0;
    host_out_bits  <= '0;
    host_out_valid <= 1'b0;
    repeat (4) @(posedge host_clk);
    reset <= 1'b0;

    after_reset_outputs();
    host_in_write_order();
    host_out_read_order();
    target_reset_pulse();
    host_in_backpressure();
    host_out_fill();

    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: htif_axi_bridge.f
verilog/htif_axi_pkg.sv
verilog/htif_reg_pkg.sv
verilog/host_fifo.sv
verilog/htif_write_port.sv
verilog/htif_read_port.sv
verilog/htif_axi_bridge.sv
verification/htif_axi_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the HTIF bridge testbench with Verilator

TOP=htif_axi_bridge_tb
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f htif_axi_bridge.f --top-module "$TOP" \
  -o "V$TOP" > "$BUILD_LOG" 2>&1
status=$?
cat "$BUILD_LOG"
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./obj_dir/V$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$SIM_LOG"; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation passed"
exit 0
